// File: font.mem
// one 8-pixel glyph row per line in hex, msb is the leftmost pixel
// rows 0-7 glyph H, 8-15 E, 16-23 L, 24-31 O, top row first
66
66
66
7E
66
66
66
00
7E
60
60
7C
60
60
7E
00
60
60
60
60
60
60
7E
00
3C
66
66
66
66
66
3C
00

// File: hello_display.f
display_pkg.sv
glyph_pkg.sv
display_timing.sv
glyph_fetch.sv
glyph_sprite.sv
starfield.sv
pixel_compose.sv
hello_display_top.sv
hello_display_sva.sv
hello_display_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = hello_display_tb
FILELIST  = hello_display.f
PASS_MSG  = TESTS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir

// File: hello_display_tb.sv
/* testbench for the fixed-text video generator
   frame and font model, sample table, mid-frame reset */
`timescale 1ns/1ps

module hello_display_tb;

    localparam int SPR_CNT = 5;
    localparam int SCALE   = 8;
    localparam int TEXT_X  = 158;
    localparam int TEXT_Y  = 208;
    localparam logic [9:0] MESSAGE = {2'd3, 2'd2, 2'd2, 2'd1, 2'd0};  // O L L E H, letter 0 low

    localparam int H_FIRST = display_pkg::H_ACTIVE - display_pkg::H_TOTAL;  // -160
    localparam int V_FIRST = display_pkg::V_ACTIVE - display_pkg::V_TOTAL;  // -45
    localparam int HS_LO   = H_FIRST + display_pkg::H_FRONT;  // sync after front porch
    localparam int HS_HI   = HS_LO + display_pkg::H_SYNC;
    localparam int VS_LO   = V_FIRST + display_pkg::V_FRONT;
    localparam int VS_HI   = VS_LO + display_pkg::V_SYNC;
    localparam int FRAME   = display_pkg::H_TOTAL * display_pkg::V_TOTAL;  // cycles per frame
    localparam int TIMEOUT = 3 * FRAME + 40_000;  // three frames plus margin
    localparam int CELL_W  = glyph_pkg::FONT_W * SCALE;  // letter pitch
    localparam logic [11:0] AMBER = 12'hFC0;

    // sample classes
    localparam int BLANK         = 0;
    localparam int SPRITE        = 1;
    localparam int STAR_OR_BLACK = 2;
    localparam int NSAMP         = 32;

    typedef struct packed {
        int x;
        int y;
        int c;
    } sample_t;

    // scan order, letter cells at x 158 + 64*m, rows from y 208
    sample_t samples [NSAMP] = '{
        '{-100, -40, BLANK},         '{320, -1, BLANK},           '{300, 207, STAR_OR_BLACK},
        '{158, 208, STAR_OR_BLACK},  '{166, 208, SPRITE},         '{174, 208, SPRITE},
        '{182, 208, STAR_OR_BLACK},  '{230, 208, SPRITE},         '{270, 208, SPRITE},
        '{294, 208, SPRITE},         '{310, 208, STAR_OR_BLACK},  '{414, 208, STAR_OR_BLACK},
        '{430, 208, SPRITE},         '{157, 210, STAR_OR_BLACK},  '{478, 210, STAR_OR_BLACK},
        '{173, 215, SPRITE},         '{270, 216, STAR_OR_BLACK},  '{422, 224, SPRITE},
        '{182, 232, SPRITE},         '{238, 232, SPRITE},         '{285, 232, STAR_OR_BLACK},
        '{358, 250, SPRITE},         '{406, 250, STAR_OR_BLACK},  '{334, 256, SPRITE},
        '{454, 256, SPRITE},         '{206, 260, SPRITE},         '{221, 260, STAR_OR_BLACK},
        '{166, 270, STAR_OR_BLACK},  '{477, 271, STAR_OR_BLACK},  '{300, 272, STAR_OR_BLACK},
        '{-100, 300, BLANK},         '{-1, 400, BLANK}
    };

    logic       clk_pix;
    logic       arst_n;
    logic       vga_hsync;
    logic       vga_vsync;
    logic [3:0] vga_r;
    logic [3:0] vga_g;
    logic [3:0] vga_b;

    logic [7:0] font [32];  // reference copy of the glyph rows
    int         mx;         // coordinate shown on the outputs
    int         my;
    bit         mvalid;
    bit         frame_full;  // frame seen from its first pixel
    int         star_cnt;
    int         errors;
    int         checks;
    int         cycles;
    int         rst_at;

    hello_display_top #(
        .SPR_CNT(SPR_CNT), .SCALE(SCALE), .TEXT_X(TEXT_X), .TEXT_Y(TEXT_Y), .MESSAGE(MESSAGE)
    ) hello_display_top_inst (
        .clk_pix, .arst_n, .vga_hsync, .vga_vsync, .vga_r, .vga_g, .vga_b
    );

    bind pixel_compose hello_display_sva hello_display_sva_inst (
        .clk_pix, .arst_n, .de, .vga_hsync, .vga_r, .vga_g, .vga_b
    );

    initial begin
        clk_pix = 1'b0;
        forever #20 clk_pix = ~clk_pix;  // 40 ns period
    end

    // frame model, one cycle behind the DUT counters
    always @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            mvalid <= 1'b0;
        end else if (!mvalid) begin
            mvalid <= 1'b1;  // first edge after release
            mx     <= H_FIRST;
            my     <= V_FIRST;
        end else if (mx == display_pkg::H_ACTIVE - 1) begin
            mx <= H_FIRST;
            my <= (my == display_pkg::V_ACTIVE - 1) ? V_FIRST : my + 1;
        end else begin
            mx <= mx + 1;
        end
    end

    // font rule: letter m, bit (x - left) / SCALE msb first, row (y - top) / SCALE
    function automatic bit letter_on(int x, int y);
        int         m;
        int         col;
        int         row;
        int         code;
        logic [7:0] bits;
        if (x < TEXT_X || x >= TEXT_X + SPR_CNT * CELL_W) return 1'b0;
        if (y < TEXT_Y || y >= TEXT_Y + glyph_pkg::FONT_H * SCALE) return 1'b0;
        m    = (x - TEXT_X) / CELL_W;
        col  = ((x - TEXT_X) % CELL_W) / SCALE;
        row  = (y - TEXT_Y) / SCALE;
        code = int'(MESSAGE[m*2 +: 2]);
        bits = font[5'(code * glyph_pkg::FONT_H + row)];
        return bits[3'(glyph_pkg::FONT_W - 1 - col)];
    endfunction

    task automatic report_mismatch(string name, int got, int expected);
        errors++;
        $display("FAIL %0t %s got %03h expected %03h at (%0d,%0d)",
                 $time, name, got, expected, mx, my);
    endtask

    // every cycle, outputs are stable at the falling edge
    always @(negedge clk_pix) begin
        logic [11:0] rgb;
        bit          act;
        bit          exp_hs;
        bit          exp_vs;
        rgb    = {vga_r, vga_g, vga_b};
        act    = (mx >= 0) && (my >= 0);
        exp_hs = !(mx >= HS_LO && mx < HS_HI);  // active low
        exp_vs = !(my >= VS_LO && my < VS_HI);
        if (!arst_n || !mvalid) begin
            frame_full = 1'b0;  // partial frame
        end else begin
            if (mx == H_FIRST && my == V_FIRST) begin
                frame_full = 1'b1;
                star_cnt   = 0;
            end
            checks += 3;
            assert (vga_hsync == exp_hs)
                else report_mismatch("vga_hsync", int'(vga_hsync), int'(exp_hs));
            assert (vga_vsync == exp_vs)
                else report_mismatch("vga_vsync", int'(vga_vsync), int'(exp_vs));
            if (!act) begin
                assert (rgb == 12'h000) else report_mismatch("vga_rgb", int'(rgb), 0);
            end else if (letter_on(mx, my)) begin
                assert (rgb == AMBER) else report_mismatch("vga_rgb", int'(rgb), int'(AMBER));
            end else begin
                assert (vga_g == vga_r) else report_mismatch("vga_g", int'(vga_g), int'(vga_r));
                assert (vga_b == vga_r) else report_mismatch("vga_b", int'(vga_b), int'(vga_r));
                if (rgb != 12'h000) star_cnt++;  // grey star
            end
            if (mx == display_pkg::H_ACTIVE - 1 && my == display_pkg::V_ACTIVE - 1
                    && frame_full) begin
                checks++;
                assert (star_cnt > 0) else begin
                    errors++;
                    $display("no star was shown over a whole frame");
                end
            end
        end
    end

    task automatic run_table();
        logic [11:0] rgb;
        for (int i = 0; i < NSAMP; i++) begin
            do @(negedge clk_pix);
            while (!(mvalid && mx == samples[i].x && my == samples[i].y));
            rgb = {vga_r, vga_g, vga_b};
            checks++;
            case (samples[i].c)
                BLANK:
                    assert (rgb == 12'h000) else report_mismatch("vga_rgb", int'(rgb), 0);
                SPRITE:
                    assert (rgb == AMBER) else report_mismatch("vga_rgb", int'(rgb), int'(AMBER));
                default:
                    assert (rgb != AMBER && vga_r == vga_g && vga_g == vga_b) else begin
                        errors++;
                        $display("FAIL %0t vga_rgb got %03h expected grey or black at (%0d,%0d)",
                                 $time, rgb, mx, my);
                    end
            endcase
        end
    endtask

    task automatic wait_frame_end();
        do @(negedge clk_pix);
        while (!(mvalid && mx == display_pkg::H_ACTIVE - 1 && my == display_pkg::V_ACTIVE - 1));
    endtask

    initial begin
        void'($urandom(2));
        $readmemh("font.mem", font);
        arst_n = 1'b0;
        repeat (5) @(negedge clk_pix);
        arst_n = 1'b1;
        run_table();
        wait_frame_end();  // frame 1 done
        rst_at = int'($urandom % (FRAME - display_pkg::H_TOTAL));  // one more hsync still ahead
        repeat (rst_at + 1) @(negedge clk_pix);  // somewhere in frame 2
        while (vga_hsync && vga_vsync && {vga_r, vga_g, vga_b} == 12'h000)
            @(negedge clk_pix);  // until an output is off its reset value
        arst_n = 1'b0;
        #1;
        checks++;
        assert (vga_hsync && vga_vsync && {vga_r, vga_g, vga_b} == 12'h000) else begin
            errors++;
            $display("reset did not force the syncs inactive and the colours to zero");
        end
        repeat (5) @(negedge clk_pix);
        arst_n = 1'b1;
        run_table();  // frame after restart
        wait_frame_end();
        @(negedge clk_pix);
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT) begin
            @(posedge clk_pix);
            cycles++;
        end
        $display("the test sequence did not finish within %0d cycles", TIMEOUT);
        $display("checks %0d errors %0d", checks, errors);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

// File: hello_display_sva.sv
/* concurrent checks on the VGA output stage
   blanking and hsync pulse width */
`timescale 1ns/1ps

module hello_display_sva (
    input logic       clk_pix,
    input logic       arst_n,
    input logic       de,
    input logic       vga_hsync,
    input logic [3:0] vga_r,
    input logic [3:0] vga_g,
    input logic [3:0] vga_b
);

    int low_cnt;  // length of the current hsync pulse

    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n)
            low_cnt <= 0;
        else if (!vga_hsync)
            low_cnt <= low_cnt + 1;
        else
            low_cnt <= 0;  // idle between pulses
    end

    // blanked pixel leaves the output register one cycle later
    blank_black: assert property (@(posedge clk_pix) disable iff (!arst_n)
        !de |=> (vga_r == 4'h0 && vga_g == 4'h0 && vga_b == 4'h0))
        else $error("colour nonzero one cycle after de low");

    hsync_width: assert property (@(posedge clk_pix) disable iff (!arst_n)
        $rose(vga_hsync) |-> (low_cnt == display_pkg::H_SYNC))
        else $error("hsync low pulse was %0d cycles", low_cnt);

endmodule

// File: hello_display_top.sv
/* fixed text video generator top level
   timing, font fetch, letter sprites, starfield, output stage */
`timescale 1ns/1ps

module hello_display_top #(
    parameter int                                         SPR_CNT = 5,    // letters
    parameter int                                         SCALE   = 8,
    parameter int                                         TEXT_X  = 158,
    parameter int                                         TEXT_Y  = 208,
    parameter logic [SPR_CNT*glyph_pkg::GLYPH_CODE_W-1:0] MESSAGE = 10'h3A4  // O L L E H, msb first
) (
    input  logic       clk_pix,
    input  logic       arst_n,
    output logic       vga_hsync,
    output logic       vga_vsync,
    output logic [3:0] vga_r,
    output logic [3:0] vga_g,
    output logic [3:0] vga_b
);

    localparam int CW = display_pkg::CORDW;
    localparam int RW = $clog2(glyph_pkg::FONT_H);

    logic signed [CW-1:0]         sx, sy;
    logic                         hsync_raw, vsync_raw, de, line;
    logic [SPR_CNT*RW-1:0]        row_idx;   // row request per sprite
    logic [glyph_pkg::FONT_W-1:0] rom_data;
    logic [SPR_CNT-1:0]           row_load;
    logic [SPR_CNT-1:0]           spr_pix;
    logic                         star_on;
    logic [7:0]                   star_level;

    display_timing display_timing_inst (
        .clk_pix, .arst_n, .sx, .sy, .hsync_raw, .vsync_raw, .de, .line
    );

    glyph_fetch #(.SPR_CNT(SPR_CNT), .MESSAGE(MESSAGE)) glyph_fetch_inst (
        .clk_pix, .arst_n, .sx, .row_idx, .rom_data, .row_load
    );

    for (genvar m = 0; m < SPR_CNT; m++) begin : g_sprite
        glyph_sprite #(
            .SCALE(SCALE),
            .X_POS(TEXT_X + m * glyph_pkg::FONT_W * SCALE),  // letter pitch
            .Y_POS(TEXT_Y)
        ) glyph_sprite_inst (
            .clk_pix, .arst_n, .sx, .sy, .line,
            .row_load(row_load[m]),
            .rom_data,
            .row_idx (row_idx[m*RW +: RW]),
            .pix     (spr_pix[m])
        );
    end

    starfield #(.SEED(21'h9A9A9), .MASK(21'h000FFF)) starfield_inst (
        .clk_pix, .arst_n, .star_on, .star_level
    );

    pixel_compose #(.SPR_CNT(SPR_CNT)) pixel_compose_inst (
        .clk_pix, .arst_n, .de, .hsync_raw, .vsync_raw, .spr_pix, .star_on, .star_level,
        .vga_hsync, .vga_vsync, .vga_r, .vga_g, .vga_b
    );

endmodule

// File: pixel_compose.sv
/* sprite over star priority with blanking
   registered VGA sync and colour outputs */
`timescale 1ns/1ps

module pixel_compose #(
    parameter int SPR_CNT = 5
) (
    input  logic               clk_pix,
    input  logic               arst_n,
    input  logic               de,
    input  logic               hsync_raw,
    input  logic               vsync_raw,
    input  logic [SPR_CNT-1:0] spr_pix,
    input  logic               star_on,
    input  logic [7:0]         star_level,
    output logic               vga_hsync,
    output logic               vga_vsync,
    output logic [3:0]         vga_r,
    output logic [3:0]         vga_g,
    output logic [3:0]         vga_b
);

    glyph_pkg::pixel_u pix;

    always_comb begin
        pix.raw = '0;  // blank and background
        if (de) begin
            if (|spr_pix)
                pix.raw = glyph_pkg::SPRITE_COLOUR;
            else if (star_on)
                pix.raw = {3{star_level[7:4]}};  // grey, equal channels
        end
    end

    // one cycle behind the coordinates
    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            vga_hsync <= 1'b1;  // inactive
            vga_vsync <= 1'b1;
            vga_r     <= '0;
            vga_g     <= '0;
            vga_b     <= '0;
        end else begin
            vga_hsync <= hsync_raw;
            vga_vsync <= vsync_raw;
            vga_r     <= pix.rgb.r;
            vga_g     <= pix.rgb.g;
            vga_b     <= pix.rgb.b;
        end
    end

endmodule

// File: starfield.sv
/* 21-bit Galois LFSR starfield
   star flag from masked upper bits, brightness from low byte */
`timescale 1ns/1ps

module starfield #(
    parameter logic [20:0] SEED = 21'h1F0A5,  // any nonzero value
    parameter logic [20:0] MASK = 21'h000FFF  // ones are ignored bits
) (
    input  logic       clk_pix,
    input  logic       arst_n,
    output logic       star_on,
    output logic [7:0] star_level
);

    localparam logic [20:0] TAPS = 21'h140000;  // x^21 + x^19 + 1

    logic [20:0] lfsr;

    // period 2^21-1 is no multiple of 420000, stars drift each frame
    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            lfsr <= SEED;
        end else begin
            lfsr <= {1'b0, lfsr[20:1]} ^ (lfsr[0] ? TAPS : 21'h0);
        end
    end

    always_comb begin
        star_on    = &(lfsr | MASK);  // upper bits all ones
        star_level = lfsr[7:0];
    end

endmodule

// File: glyph_sprite.sv
/* one scaled 8x8 glyph sprite
   frame state, row latch per line, horizontal scale counter */
`timescale 1ns/1ps

module glyph_sprite #(
    parameter int SCALE = 8,    // enlargement in x and y
    parameter int X_POS = 158,  // left edge
    parameter int Y_POS = 208   // top edge
) (
    input  logic                                 clk_pix,
    input  logic                                 arst_n,
    input  logic signed [display_pkg::CORDW-1:0] sx,
    input  logic signed [display_pkg::CORDW-1:0] sy,
    input  logic                                 line,
    input  logic                                 row_load,
    input  logic [glyph_pkg::FONT_W-1:0]         rom_data,
    output logic [$clog2(glyph_pkg::FONT_H)-1:0] row_idx,  // glyph row wanted next fetch
    output logic                                 pix
);

    localparam int CW     = display_pkg::CORDW;
    localparam int RW     = $clog2(glyph_pkg::FONT_H);
    localparam int BW     = $clog2(glyph_pkg::FONT_W);
    localparam int SW     = $clog2(SCALE + 1);  // holds 0..SCALE-1, also for SCALE=1
    localparam int X_LAST = X_POS + glyph_pkg::FONT_W * SCALE;  // first pixel past span

    localparam logic [1:0] ST_IDLE   = 2'd0;
    localparam logic [1:0] ST_ACTIVE = 2'd1;
    localparam logic [1:0] ST_DONE   = 2'd2;

    logic [1:0]                  state;
    logic [SW-1:0]               line_cnt;  // screen lines within glyph row
    logic [SW-1:0]               sub_cnt;   // pixels within glyph bit
    logic [BW-1:0]               bit_idx;   // (sx - X_POS) / SCALE
    logic [glyph_pkg::FONT_W-1:0] row_bits;
    logic                        in_span;

    // vertical state, all steps on the line pulse
    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            state    <= ST_IDLE;
            row_idx  <= '0;
            line_cnt <= '0;
        end else if (line) begin
            case (state)
                ST_IDLE: begin
                    if (sy == CW'(Y_POS)) begin  // top line of text
                        state    <= ST_ACTIVE;
                        row_idx  <= '0;
                        line_cnt <= '0;
                    end
                end
                ST_ACTIVE: begin
                    if (line_cnt == SW'(SCALE - 1)) begin
                        line_cnt <= '0;
                        if (row_idx == RW'(glyph_pkg::FONT_H - 1))
                            state <= ST_DONE;  // all rows drawn
                        else
                            row_idx <= row_idx + RW'(1);
                    end else begin
                        line_cnt <= line_cnt + SW'(1);
                    end
                end
                ST_DONE: begin
                    if (sy == CW'(display_pkg::V_STA)) state <= ST_IDLE;  // new frame
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // free-running, realigned one pixel before the left edge
    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            sub_cnt <= '0;
            bit_idx <= '0;
        end else if (sx == CW'(X_POS - 1)) begin
            sub_cnt <= '0;
            bit_idx <= '0;
        end else if (sub_cnt == SW'(SCALE - 1)) begin
            sub_cnt <= '0;
            bit_idx <= bit_idx + BW'(1);  // wraps past span, unused there
        end else begin
            sub_cnt <= sub_cnt + SW'(1);
        end
    end

    always_ff @(posedge clk_pix) begin
        if (row_load) row_bits <= rom_data;  // fetched in h-blank
    end

    always_comb begin
        in_span = (sx >= CW'(X_POS)) && (sx < CW'(X_LAST));
        pix = (state == ST_ACTIVE) && in_span
            && row_bits[BW'(glyph_pkg::FONT_W - 1) - bit_idx];  // msb is leftmost
    end

endmodule

// File: glyph_fetch.sv
/* synchronous font ROM loaded from font.mem
   per-sprite row read slots in horizontal blanking */
`timescale 1ns/1ps

module glyph_fetch #(
    parameter int                                             SPR_CNT = 5,
    parameter logic [SPR_CNT*glyph_pkg::GLYPH_CODE_W-1:0]     MESSAGE = 10'h3A4
) (
    input  logic                                        clk_pix,
    input  logic                                        arst_n,
    input  logic signed [display_pkg::CORDW-1:0]        sx,
    input  logic [SPR_CNT*$clog2(glyph_pkg::FONT_H)-1:0] row_idx,   // 3 bits per sprite
    output logic [glyph_pkg::FONT_W-1:0]                rom_data,
    output logic [SPR_CNT-1:0]                          row_load   // rom_data valid for sprite m
);

    localparam int CW    = display_pkg::CORDW;
    localparam int RW    = $clog2(glyph_pkg::FONT_H);
    localparam int GCW   = glyph_pkg::GLYPH_CODE_W;
    localparam int SLOT0 = -2 * SPR_CNT;  // sprite 0 slot, late in h-blank

    logic [glyph_pkg::FONT_W-1:0] rom [glyph_pkg::ROM_DEPTH];  // 8 rows per glyph
    logic [glyph_pkg::ROM_AW-1:0] addr;
    logic [SPR_CNT-1:0]           slot;  // one-hot read grant

    initial $readmemh("font.mem", rom);

    // one sprite per cycle, address is code then row
    always_comb begin
        addr = '0;
        for (int i = 0; i < SPR_CNT; i++) begin
            slot[i] = (sx == CW'(SLOT0 + i));
            if (slot[i])
                addr = {MESSAGE[i*GCW +: GCW], row_idx[i*RW +: RW]};
        end
    end

    always_ff @(posedge clk_pix) begin
        rom_data <= rom[addr];  // one cycle read latency
    end

    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) row_load <= '0;
        else         row_load <= slot;  // aligned with rom_data
    end

endmodule

// File: display_timing.sv
/* 640x480 line and frame counters with signed coordinates
   raw active-low syncs, display enable, line start pulse */
`timescale 1ns/1ps

module display_timing (
    input  logic                                 clk_pix,
    input  logic                                 arst_n,
    output logic signed [display_pkg::CORDW-1:0] sx,  // -160..639
    output logic signed [display_pkg::CORDW-1:0] sy,  // -45..479
    output logic                                 hsync_raw,
    output logic                                 vsync_raw,
    output logic                                 de,
    output logic                                 line
);

    localparam int CW = display_pkg::CORDW;

    localparam int H_STA  = display_pkg::H_STA;             // -160
    localparam int HS_STA = H_STA + display_pkg::H_FRONT;   // -144
    localparam int HS_END = HS_STA + display_pkg::H_SYNC;   // -48, first pixel past sync
    localparam int H_END  = display_pkg::H_ACTIVE - 1;      // 639

    localparam int V_STA  = display_pkg::V_STA;             // -45
    localparam int VS_STA = V_STA + display_pkg::V_FRONT;   // -35
    localparam int VS_END = VS_STA + display_pkg::V_SYNC;   // -33
    localparam int V_END  = display_pkg::V_ACTIVE - 1;      // 479

    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            sx <= CW'(H_STA);
            sy <= CW'(V_STA);
        end else if (sx == CW'(H_END)) begin  // last pixel of line
            sx <= CW'(H_STA);
            sy <= (sy == CW'(V_END)) ? CW'(V_STA) : sy + CW'(1);  // frame wrap
        end else begin
            sx <= sx + CW'(1);
        end
    end

    // front porch comes first, then sync, then back porch
    always_comb begin
        hsync_raw = ~(sx >= CW'(HS_STA) && sx < CW'(HS_END));  // active low
        vsync_raw = ~(sy >= CW'(VS_STA) && sy < CW'(VS_END));
        de        = (sx >= CW'(0)) && (sy >= CW'(0));  // active area only
        line      = (sx == CW'(H_STA));  // first blank pixel of each line
    end

endmodule

// File: glyph_pkg.sv
/* font geometry and ROM sizing for the 8x8 glyph set
   sprite colour, pixel word with raw and rgb views */
package glyph_pkg;

    localparam int FONT_W = 8;  // glyph width, also ROM word width
    localparam int FONT_H = 8;  // glyph height in rows

    // glyph codes: H=0 E=1 L=2 O=3
    localparam int GLYPHS       = 4;
    localparam int ROM_DEPTH    = GLYPHS * FONT_H;    // 32 rows
    localparam int ROM_AW       = $clog2(ROM_DEPTH);  // 5
    localparam int GLYPH_CODE_W = $clog2(GLYPHS);     // 2

    localparam logic [11:0] SPRITE_COLOUR = 12'hFC0;  // amber

    // one 12-bit pixel, written whole and read per channel
    typedef union packed {
        logic [11:0] raw;
        struct packed {
            logic [3:0] r;  // msb nibble
            logic [3:0] g;
            logic [3:0] b;
        } rgb;
    } pixel_u;

endpackage

// File: display_pkg.sv
/* 640x480 60 Hz video timing constants
   signed coordinate width and derived frame totals */
package display_pkg;

    localparam int CORDW = 16;  // signed screen coordinate width

    // horizontal timing, pixels
    localparam int H_ACTIVE = 640;
    localparam int H_FRONT  = 16;
    localparam int H_SYNC   = 96;
    localparam int H_BACK   = 48;

    // vertical timing, lines
    localparam int V_ACTIVE = 480;
    localparam int V_FRONT  = 10;
    localparam int V_SYNC   = 2;
    localparam int V_BACK   = 33;

    localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;  // 800
    localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;  // 525

    // blanking sits at negative coordinates, first blank pixel/line
    localparam int H_STA = H_ACTIVE - H_TOTAL;  // -160
    localparam int V_STA = V_ACTIVE - V_TOTAL;  // -45

endpackage
